// ==== filelist.f ====
+incdir+.
fm_pkg.sv
freq_result_if.sv
gate_gen.sv
freq_channel.sv
result_collector.sv
freq_monitor_top.sv
tb_freq_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_freq_monitor -o tb_freq_monitor

out=$(./obj_dir/tb_freq_monitor)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'all tests passed'; then
    exit 0
fi
exit 1

// ==== tb_freq_monitor.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module tb_freq_monitor;
    import fm_pkg::*;

    localparam int NCH         = `FM_NUM_CHANNELS;
    localparam int GATE        = `FM_GATE_CYCLES;
    localparam int CLK_NS      = 100;
    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG_NS = NUM_TESTS * 6 * GATE * CLK_NS;
    localparam int COUNT_MAX   = (1 << `FM_COUNT_WIDTH) - 1;
    localparam int MEAS_PERIOD_NS [4] = '{10, 40, 70, 130};

    logic           ps_clk;
    logic           arst_n_i;
    logic [NCH-1:0] meas_clk_i;
    logic           result_valid_o;
    logic           result_ready_i;
    chan_t          result_chan_o;
    count_t         result_count_o;
    logic           result_overflow_o;

    int errors;
    int checks;
    int cyc; // ps_clk cycles since reset release

    freq_monitor_top u_freq_monitor_top (
        .ps_clk            (ps_clk),
        .arst_n_i          (arst_n_i),
        .meas_clk_i        (meas_clk_i),
        .result_valid_o    (result_valid_o),
        .result_ready_i    (result_ready_i),
        .result_chan_o     (result_chan_o),
        .result_count_o    (result_count_o),
        .result_overflow_o (result_overflow_o)
    );

    always #(CLK_NS / 2) ps_clk = ~ps_clk;

    for (genvar i = 0; i < NCH; i++) begin : g_mclk
        localparam int HALF_NS = MEAS_PERIOD_NS[i] / 2;
        logic clk;
        initial clk = 1'b0;
        always #(HALF_NS) clk = ~clk;
        assign meas_clk_i[i] = clk;
    end

    // Edges of the measured clock over one gate period
    function automatic int gate_edges(input int ch);
        return GATE * CLK_NS / MEAS_PERIOD_NS[ch];
    endfunction

    function automatic count_t expected_count(input int ch);
        if (gate_edges(ch) > COUNT_MAX) return '1;
        return count_t'(gate_edges(ch));
    endfunction

    function automatic logic expected_overflow(input int ch);
        return gate_edges(ch) > COUNT_MAX;
    endfunction

    function automatic int count_tol(input int ch);
        return expected_overflow(ch) ? 0 : 1; // Saturated value is exact
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic check_count(input count_t got, input count_t exp, input int tol,
                               input string what);
        int diff;
        diff = int'(got) - int'(exp);
        checks = checks + 1;
        if (diff > tol || diff < -tol) begin
            report_error($sformatf("%s is %0d, expected %0d +/- %0d", what, got, exp, tol));
        end
    endtask

    task automatic check_chan(input chan_t got, input chan_t exp, input string what);
        checks = checks + 1;
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks = checks + 1;
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_result(input chan_t ch, input count_t cnt, input logic ovf);
        int idx;
        idx = int'(ch);
        check_count(cnt, expected_count(idx), count_tol(idx),
                    $sformatf("count of channel %0d", idx));
        check_flag(ovf, expected_overflow(idx), $sformatf("overflow of channel %0d", idx));
    endtask

    // Result sampled here is accepted on the next edge when xfer is set
    task automatic next_cycle(input logic ready, output logic xfer);
        @(posedge ps_clk);
        #1;
        result_ready_i = ready;
        cyc = cyc + 1;
        xfer = result_valid_o && ready;
    endtask

    task automatic test_reset_quiet();
        logic xfer;
        for (int i = 0; i < 2 * GATE - 1; i++) begin
            next_cycle(1'b1, xfer);
            if (result_valid_o) report_error("result_valid_o high before second gate");
        end
    endtask

    task automatic test_accuracy();
        logic xfer;
        int   seen [NCH];
        foreach (seen[i]) seen[i] = 0;
        for (int i = 0; i < 3 * GATE; i++) begin
            next_cycle(1'b1, xfer);
            if (xfer && result_chan_o != chan_t'(0)) begin
                check_result(result_chan_o, result_count_o, result_overflow_o);
                seen[int'(result_chan_o)]++;
            end
        end
        for (int ch = 1; ch < NCH; ch++) begin
            if (seen[ch] == 0) report_error($sformatf("channel %0d never reported", ch));
        end
    endtask

    task automatic test_saturation();
        logic xfer;
        int   hits;
        hits = 0;
        for (int i = 0; i < 2 * GATE; i++) begin
            next_cycle(1'b1, xfer);
            if (xfer && result_chan_o == chan_t'(0)) begin
                check_count(result_count_o, '1, 0, "saturated count of channel 0");
                check_flag(result_overflow_o, 1'b1, "overflow of channel 0");
                hits++;
            end
        end
        if (hits == 0) report_error("channel 0 never reported");
    endtask

    task automatic test_fair_drain();
        logic xfer;
        int   seen [NCH];
        while (cyc % GATE != 0) next_cycle(1'b1, xfer);
        for (int w = 0; w < 3; w++) begin
            foreach (seen[i]) seen[i] = 0;
            for (int i = 0; i < GATE; i++) begin
                next_cycle(1'b1, xfer);
                if (xfer) seen[int'(result_chan_o)]++;
            end
            for (int ch = 0; ch < NCH; ch++) begin
                if (seen[ch] != 1) begin
                    report_error($sformatf("channel %0d seen %0d times in gate window %0d",
                                           ch, seen[ch], w));
                end
            end
        end
    endtask

    task automatic test_backpressure();
        logic   xfer;
        logic   held;
        chan_t  held_ch;
        count_t held_cnt;
        logic   held_ovf;
        int     hold_periods;
        int     seen [NCH];
        held = 1'b0;
        held_ch = '0;
        held_cnt = '0;
        held_ovf = 1'b0;
        hold_periods = 1 + int'($urandom % 3);
        for (int i = 0; i < hold_periods * GATE; i++) begin
            next_cycle(1'b0, xfer);
            if (held) begin
                if (!result_valid_o) report_error("result_valid_o dropped while stalled");
                check_chan(result_chan_o, held_ch, "stalled channel");
                check_count(result_count_o, held_cnt, 0, "stalled count");
                check_flag(result_overflow_o, held_ovf, "stalled overflow");
            end else if (result_valid_o) begin
                held = 1'b1;
                held_ch = result_chan_o;
                held_cnt = result_count_o;
                held_ovf = result_overflow_o;
                check_result(held_ch, held_cnt, held_ovf);
            end
        end
        if (!held) report_error("no result appeared while the output was stalled");
        foreach (seen[i]) seen[i] = 0;
        for (int i = 0; i < 2 * GATE; i++) begin
            next_cycle(1'b1, xfer);
            if (xfer) begin
                check_result(result_chan_o, result_count_o, result_overflow_o);
                seen[int'(result_chan_o)]++;
            end
        end
        for (int ch = 0; ch < NCH; ch++) begin
            if (seen[ch] == 0) report_error($sformatf("channel %0d silent after release", ch));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        cyc = 0;
        ps_clk = 1'b0;
        arst_n_i = 1'b0;
        result_ready_i = 1'b0;
        void'($urandom(32'h9f231460));
        repeat (10) @(posedge ps_clk);
        #1;
        arst_n_i = 1'b1;
        test_reset_quiet();
        test_accuracy();
        test_saturation();
        test_fair_drain();
        test_backpressure();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== freq_monitor_top.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module freq_monitor_top (
    input  logic                        ps_clk,
    input  logic                        arst_n_i,
    input  logic [`FM_NUM_CHANNELS-1:0] meas_clk_i,
    output logic                        result_valid_o,
    input  logic                        result_ready_i,
    output fm_pkg::chan_t               result_chan_o,
    output fm_pkg::count_t              result_count_o,
    output logic                        result_overflow_o
);

    logic gate;

    freq_result_if res_if [`FM_NUM_CHANNELS] ();

    gate_gen u_gate_gen (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .gate_o   (gate)
    );

    // One measurement channel per clock
    for (genvar i = 0; i < `FM_NUM_CHANNELS; i++) begin : g_chan
        freq_channel u_freq_channel (
            .ps_clk     (ps_clk),
            .arst_n_i   (arst_n_i),
            .meas_clk_i (meas_clk_i[i]),
            .gate_i     (gate),
            .res        (res_if[i])
        );
    end

    result_collector u_result_collector (
        .ps_clk            (ps_clk),
        .arst_n_i          (arst_n_i),
        .res               (res_if),
        .result_valid_o    (result_valid_o),
        .result_ready_i    (result_ready_i),
        .result_chan_o     (result_chan_o),
        .result_count_o    (result_count_o),
        .result_overflow_o (result_overflow_o)
    );

endmodule

// ==== result_collector.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module result_collector (
    input  logic           ps_clk,
    input  logic           arst_n_i,
    freq_result_if.sink    res [`FM_NUM_CHANNELS],
    output logic           result_valid_o,
    input  logic           result_ready_i,
    output fm_pkg::chan_t  result_chan_o,
    output fm_pkg::count_t result_count_o,
    output logic           result_overflow_o
);
    import fm_pkg::*;

    localparam int NCH = `FM_NUM_CHANNELS;

    logic [NCH-1:0] valid_vec;
    logic [NCH-1:0] ovf_vec;
    logic [NCH-1:0] grant_vec;
    count_t         cnt_arr [NCH];
    chan_t          last_q;   // Last served channel
    chan_t          pick;
    logic           found;
    logic           take;

    for (genvar i = 0; i < NCH; i++) begin : g_tap
        assign valid_vec[i]  = res[i].valid;
        assign ovf_vec[i]    = res[i].overflow;
        assign cnt_arr[i]    = res[i].count;
        assign res[i].ready  = grant_vec[i];
    end

    // Register free or emptied on this edge
    assign take = !result_valid_o || result_ready_i;

    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last_q;
        for (int off = 1; off <= NCH; off++) begin
            idx = (int'(last_q) + off) % NCH;
            if (!found && valid_vec[idx]) begin
                found = 1'b1;
                pick  = chan_t'(idx);
            end
        end
    end

    always_comb begin
        grant_vec = '0;
        if (take && found) grant_vec[pick] = 1'b1;
    end

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
            last_q         <= chan_t'(NCH - 1); // Channel 0 served first
        end else if (take) begin
            result_valid_o <= found;
            if (found) last_q <= pick;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (take && found) begin
            result_chan_o     <= pick;
            result_count_o    <= cnt_arr[pick];
            result_overflow_o <= ovf_vec[pick];
        end
    end

endmodule

// ==== freq_channel.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module freq_channel (
    input  logic          ps_clk,
    input  logic          arst_n_i,
    input  logic          meas_clk_i,
    input  logic          gate_i,
    freq_result_if.source res
);
    import fm_pkg::*;

    localparam int SYNC_W = `FM_SYNC_STAGES;

    logic              gate_tgl_q;

    // Measured clock domain
    logic [SYNC_W-1:0] meas_rst_sync_q;
    logic              meas_rst_n;
    logic [SYNC_W-1:0] gate_sync_q;
    logic              gate_seen_q;
    logic              meas_gate;
    count_t            edge_cnt_q;
    logic              edge_ovf_q;
    count_t            hold_cnt_q;
    logic              hold_ovf_q;
    logic              done_tgl_q;

    // Back in ps_clk
    logic [SYNC_W-1:0] done_sync_q;
    logic              done_seen_q;
    logic              done_pulse;
    chan_state_t       state_q;
    count_t            res_cnt_q;
    logic              res_ovf_q;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gate_tgl_q <= 1'b0;
        end else if (gate_i) begin
            gate_tgl_q <= ~gate_tgl_q;
        end
    end

    // Release of reset follows meas_clk_i
    always_ff @(posedge meas_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            meas_rst_sync_q <= '0;
        end else begin
            meas_rst_sync_q <= {meas_rst_sync_q[SYNC_W-2:0], 1'b1};
        end
    end

    assign meas_rst_n = meas_rst_sync_q[SYNC_W-1];

    always_ff @(posedge meas_clk_i or negedge meas_rst_n) begin
        if (!meas_rst_n) begin
            gate_sync_q <= '0;
            gate_seen_q <= 1'b0;
        end else begin
            gate_sync_q <= {gate_sync_q[SYNC_W-2:0], gate_tgl_q};
            gate_seen_q <= gate_sync_q[SYNC_W-1];
        end
    end

    assign meas_gate = gate_sync_q[SYNC_W-1] ^ gate_seen_q;

    always_ff @(posedge meas_clk_i or negedge meas_rst_n) begin
        if (!meas_rst_n) begin
            edge_cnt_q <= '0;
            edge_ovf_q <= 1'b0;
            done_tgl_q <= 1'b0;
        end else if (meas_gate) begin
            edge_cnt_q <= count_t'(1); // Gate edge itself counts
            edge_ovf_q <= 1'b0;
            done_tgl_q <= ~done_tgl_q;
        end else if (edge_cnt_q == '1) begin
            edge_ovf_q <= 1'b1; // Saturate
        end else begin
            edge_cnt_q <= edge_cnt_q + count_t'(1);
        end
    end

    always_ff @(posedge meas_clk_i) begin
        if (meas_gate) begin
            hold_cnt_q <= edge_cnt_q;
            hold_ovf_q <= edge_ovf_q;
        end
    end

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_sync_q <= '0;
            done_seen_q <= 1'b0;
        end else begin
            done_sync_q <= {done_sync_q[SYNC_W-2:0], done_tgl_q};
            done_seen_q <= done_sync_q[SYNC_W-1];
        end
    end

    // Hold registers are stable for most of a gate period here
    assign done_pulse = done_sync_q[SYNC_W-1] ^ done_seen_q;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= WAIT_FIRST;
        end else begin
            case (state_q)
                WAIT_FIRST: if (done_pulse) state_q <= IDLE; // Partial count dropped
                IDLE:       if (done_pulse) state_q <= PENDING;
                PENDING:    if (!done_pulse && res.ready) state_q <= IDLE;
                default:    state_q <= WAIT_FIRST;
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (done_pulse && state_q != WAIT_FIRST) begin
            res_cnt_q <= hold_cnt_q; // Newest result replaces an untaken one
            res_ovf_q <= hold_ovf_q;
        end
    end

    assign res.valid    = (state_q == PENDING);
    assign res.count    = res_cnt_q;
    assign res.overflow = res_ovf_q;

endmodule

// ==== gate_gen.sv ====
`timescale 1ns/1ps
`include "fm_cfg.svh"

module gate_gen (
    input  logic ps_clk,
    input  logic arst_n_i,
    output logic gate_o
);

    localparam int CNT_W = (`FM_GATE_CYCLES > 1) ? $clog2(`FM_GATE_CYCLES) : 1;

    logic [CNT_W-1:0] period_cnt_q;
    logic             period_end;

    assign period_end = (period_cnt_q == CNT_W'(`FM_GATE_CYCLES - 1));

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            period_cnt_q <= '0;
            gate_o       <= 1'b0;
        end else begin
            if (period_end) begin
                period_cnt_q <= '0;
            end else begin
                period_cnt_q <= period_cnt_q + CNT_W'(1);
            end
            gate_o <= period_end; // One cycle per period
        end
    end

endmodule

// ==== freq_result_if.sv ====
`timescale 1ns/1ps

// One channel's result towards the collector
interface freq_result_if;
    import fm_pkg::*;

    logic   valid;
    logic   ready;
    count_t count;
    logic   overflow; // Counter saturated during this gate

    modport source (
        output valid,
        output count,
        output overflow,
        input  ready
    );

    modport sink (
        input  valid,
        input  count,
        input  overflow,
        output ready
    );

endinterface

// ==== fm_pkg.sv ====
`include "fm_cfg.svh"

package fm_pkg;

    localparam int CHAN_W = (`FM_NUM_CHANNELS > 1) ? $clog2(`FM_NUM_CHANNELS) : 1;

    // Measured-clock rising edges per gate period
    typedef logic [`FM_COUNT_WIDTH-1:0] count_t;

    typedef logic [CHAN_W-1:0] chan_t; // Channel number

    // ps_clk side result holder
    typedef enum logic [1:0] {WAIT_FIRST, IDLE, PENDING} chan_state_t;

endpackage

// ==== fm_cfg.svh ====
`ifndef FM_CFG_SVH
`define FM_CFG_SVH

// Number of measured clocks
`define FM_NUM_CHANNELS 4

// Count width, kept small so overflow is reachable
`define FM_COUNT_WIDTH 10

`define FM_GATE_CYCLES 200 // ps_clk cycles per gate period

`define FM_SYNC_STAGES 2 // Flops per CDC synchronizer

`endif
